/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mips_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the simulator exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram import mips_pkg::*; (
    input  logic        clk,
    input  mem_req_t    req,
    output logic [31:0] readdata
);

    localparam int aw = $clog2(ram_words);

    logic [31:0] mem [ram_words];

    // word index, byte lanes ignored (word accesses only)
    logic [aw-1:0] idx;

    assign idx = req.addr[aw+1:2];

    // read answers in the same cycle as the request
    assign readdata = req.read ? mem[idx] : 32'd0;

    always_ff @(posedge clk) begin
        if (req.write) begin
            mem[idx] <= req.wdata;
        end
    end

    // arithmetic series, the program loads words 0..14
    initial begin
        for (int k = 0; k < ram_words; k++) begin
            mem[k] = data_base + 32'(k) * data_step;
        end
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import mips_pkg::*; (
    input  logic [31:0] instr,
    output decoded_t    dec
);

    // raw fields
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    // register fields sit in the same spot for i-type and r-type
    assign dec.rs  = instr[25:21];
    assign dec.rt  = instr[20:16];
    assign dec.imm = {{16{imm16[15]}}, imm16};

    always_comb begin
        // anything not supported falls through as a nop
        dec.cls = cls_nop;
        case (opcode_e'(opcode))
            op_lw: begin
                dec.cls = cls_load;
            end
            op_sw: begin
                dec.cls = cls_store;
            end
            op_special: begin
                // sll, including the all-zero nop, does nothing here
                case (funct_e'(funct))
                    fn_jr:   dec.cls = cls_jump;
                    fn_sll:  dec.cls = cls_nop;
                    default: dec.cls = cls_nop;
                endcase
            end
            default: begin
                // j and others are not executed
                dec.cls = cls_nop;
            end
        endcase
    end

endmodule

/* hw/instr_rom.sv */
`timescale 1ns/1ps

module instr_rom import mips_pkg::*; (
    // combinational fetch, no clock involved
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    logic [31:0] rom [rom_words];

    // byte offset from the boot vector, then word index
    logic [31:0] offset;
    logic [$clog2(rom_words)-1:0] word_idx;

    assign offset   = instr_address - reset_vector;
    assign word_idx = offset[$clog2(rom_words)+1:2];

    assign instr_readdata = rom[word_idx];

    initial begin
        // instruction fields, shared by all three formats
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [15:0] imm;
        logic [25:0] j_addr;
        int          w;

        // unused words hold j 0, which is the halt marker
        opcode = op_j;
        j_addr = 26'd0;
        for (int k = 0; k < rom_words; k++) begin
            rom[k] = {opcode, j_addr};
        end

        w = 0;

        // lw ri, (i-2)*4(r0) for r2..r16
        for (int i = 2; i <= 16; i++) begin
            opcode = op_lw;
            rs     = 5'd0;
            rt     = 5'(i);
            imm    = 16'((i - 2) * 4);
            rom[w] = {opcode, rs, rt, imm};
            w++;
        end

        // sw ri, 0x100+(i-2)*4(r0) for r2..r15
        for (int i = 2; i <= 15; i++) begin
            opcode = op_sw;
            rs     = 5'd0;
            rt     = 5'(i);
            imm    = 16'(16'h100 + (i - 2) * 4);
            rom[w] = {opcode, rs, rt, imm};
            w++;
        end

        // jr r0, target 0 halts after the delay slot
        opcode = op_special;
        rs     = 5'd0;
        rt     = 5'd0;
        rd     = 5'd0;
        shamt  = 5'd0;
        funct  = fn_jr;
        rom[w] = {opcode, rs, rt, rd, shamt, funct};
        w++;

        // delay slot: nop is sll r0, r0, 0
        funct  = fn_sll;
        rom[w] = {opcode, rs, rt, rd, shamt, funct};
    end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output mem_req_t    mem_req,
    input  logic [31:0] mem_rdata,
    output logic        halted
);

    decoded_t    dec;
    logic [31:0] regs [32];

    // operand values, r0 forced to zero
    logic [31:0] rs_val;
    logic [31:0] rt_val;

    // instruction may take effect only before halt
    logic        active;
    logic        jump;
    logic [31:0] eff_addr;

    instr_decoder i_decoder (
        .instr (instr),
        .dec   (dec)
    );

    pc_unit i_pc_unit (
        .clk         (clk),
        .rst         (rst),
        .jump        (jump),
        .jump_target (rs_val),
        .pc          (pc),
        .halted      (halted)
    );

    assign rs_val = (dec.rs == 5'd0) ? 32'd0 : regs[dec.rs];
    assign rt_val = (dec.rt == 5'd0) ? 32'd0 : regs[dec.rt];

    assign active   = !halted;
    assign eff_addr = rs_val + dec.imm;

    // jr hands rs to the pc unit, redirect happens after the slot
    assign jump = active && (dec.cls == cls_jump);

    // one request per cycle, at most one of read/write
    assign mem_req.read  = active && (dec.cls == cls_load);
    assign mem_req.write = active && (dec.cls == cls_store);
    assign mem_req.addr  = eff_addr;
    assign mem_req.wdata = rt_val;

    // register file, load data written back at the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= 32'd0;
            end
        end else if (mem_req.read && dec.rt != 5'd0) begin
            regs[dec.rt] <= mem_rdata;
        end
    end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

    // first fetch address after reset, kseg1 boot rom
    localparam logic [31:0] reset_vector = 32'hBFC00000;

    // memory depths in 32-bit words
    localparam int rom_words = 4096;
    localparam int ram_words = 256;

    // preloaded data word k = data_base + k * data_step
    localparam logic [31:0] data_base = 32'h00001000;
    localparam logic [31:0] data_step = 32'h00000011;

    // primary opcode field, instr[31:26]
    // op_j only appears as the halt filler word in the rom
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special opcode, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_jr  = 6'h08
    } funct_e;

    // what the core has to do with the fetched word
    typedef enum logic [1:0] {
        cls_nop   = 2'd0,
        cls_load  = 2'd1,
        cls_store = 2'd2,
        cls_jump  = 2'd3
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic [31:0]  imm;
    } decoded_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

/* hw/mips_top.sv */
`timescale 1ns/1ps

module mips_top import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        halted,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data
);

    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rdata;
    mem_req_t    mem_req;

    mips_core i_core (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .pc        (pc),
        .mem_req   (mem_req),
        .mem_rdata (rdata),
        .halted    (halted)
    );

    // fetch straight from the pc
    instr_rom i_rom (
        .instr_address  (pc),
        .instr_readdata (instr)
    );

    data_ram i_ram (
        .clk      (clk),
        .req      (mem_req),
        .readdata (rdata)
    );

    // store observation, write strobe is a single-cycle pulse per sw
    assign store_valid = mem_req.write;
    assign store_addr  = mem_req.addr;
    assign store_data  = mem_req.wdata;

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        jump,
    input  logic [31:0] jump_target,
    output logic [31:0] pc,
    output logic        halted
);

    // jr seen last cycle, current cycle is the delay slot
    logic        pending;
    logic [31:0] target_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= reset_vector;
            halted  <= 1'b0;
            pending <= 1'b0;
        end else if (!halted) begin
            if (pending) begin
                pending <= 1'b0;
                // jump to 0 is the halt convention, pc stays on the slot
                if (target_q == 32'd0) begin
                    halted <= 1'b1;
                end else begin
                    pc <= target_q;
                end
            end else begin
                pc <= pc + 32'd4;
                if (jump) begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // target only matters while pending is set
    always_ff @(posedge clk) begin
        if (jump && !pending) begin
            target_q <= jump_target;
        end
    end

endmodule

/* testbench/mips_asserts.sv */
`timescale 1ns/1ps

module mips_asserts import mips_pkg::*; (
    input logic     clk,
    input logic     rst,
    input mem_req_t mem_req,
    input logic     halted
);

    // one request per cycle, never a read and a write together
    read_write_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_req.read && mem_req.write)
    ) else $error("memory request has read and write both set");

    // a halted core must not touch data memory
    no_write_when_halted: assert property (
        @(posedge clk) disable iff (rst) !(halted && mem_req.write)
    ) else $error("write strobe seen while halted");

    // halt is sticky, only reset clears it
    halt_sticky: assert property (
        @(posedge clk) disable iff (rst) halted |=> halted
    ) else $error("halted dropped without reset");

endmodule

// attach to every core instance
bind mips_core mips_asserts i_asserts (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .halted  (halted)
);

/* testbench/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb import mips_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        halted;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    mips_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .halted      (halted),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // series word that the k-th load brings into r(k+2)
    function automatic logic [31:0] expected_word(input int k);
        return data_base + 32'(k) * data_step;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    // reset, then follow the program cycle by cycle until halt
    task automatic run_program(input string run_name);
        int cycle;
        int stores;

        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        cycle  = 0;
        stores = 0;

        // sample in the middle of each cycle, away from the edge
        @(negedge clk);
        check_flag({run_name, " halted after reset"}, 1'b0, halted);

        // instruction n is on the bus at sample n
        while (!halted) begin
            if (store_valid) begin
                if (stores >= 14) begin
                    report_failure({run_name, ": more than fourteen stores were seen"});
                end
                check_word({run_name, " store address"},
                           32'h100 + 32'(stores) * 32'd4, store_addr);
                check_word({run_name, " store data"}, expected_word(stores), store_data);
                stores++;
            end
            if (cycle >= 200) begin
                report_failure({run_name, ": core did not halt within 200 cycles"});
            end
            @(negedge clk);
            cycle++;
        end

        check_word({run_name, " store count"}, 32'd14, 32'(stores));
        // 29 memory ops, jr and its delay slot
        check_word({run_name, " halt cycle"}, 32'd31, 32'(cycle));
        check_flag({run_name, " store at halt"}, 1'b0, store_valid);

        // quiet window after halt
        repeat (50) begin
            @(negedge clk);
            check_flag({run_name, " halted held"}, 1'b1, halted);
            check_flag({run_name, " store after halt"}, 1'b0, store_valid);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;

        run_program("first run");
        // second pass shows the stores left words 0..14 alone
        run_program("second run");

        $display("Done: no errors");
        $finish;
    end

endmodule

/* verilog.f */
hw/mips_pkg.sv
hw/instr_rom.sv
hw/data_ram.sv
hw/instr_decoder.sv
hw/pc_unit.sv
hw/mips_core.sv
hw/mips_top.sv
testbench/mips_asserts.sv
testbench/mips_tb.sv
